// File: hdl/attr_interp_pkg.sv
// Attribute interpolator shared definitions
// Widths, step command codes, fixed-point slice positions and pipeline depth

package attr_interp_pkg;

    ////////////////////////////////////////
    // Widths
    ////////////////////////////////////////
    localparam int attrib_width     = 32;   // Accumulators, start values, increments
    localparam int color_width      = 8;
    localparam int depth_width      = 16;
    localparam int screen_pos_width = 11;
    localparam int index_width      = 32;
    localparam int keep_width       = 1;
    localparam int cmd_width        = 2;

    ////////////////////////////////////////
    // Rasterizer step commands
    ////////////////////////////////////////
    localparam logic [cmd_width-1:0] cmd_init  = 2'd0;
    localparam logic [cmd_width-1:0] cmd_x_inc = 2'd1;
    localparam logic [cmd_width-1:0] cmd_x_dec = 2'd2;
    localparam logic [cmd_width-1:0] cmd_y_inc = 2'd3;

    // S7.24 colour accumulator cut down to S7.8
    localparam int color_msb = 31;
    localparam int color_lsb = 16;

    // S1.30 depth, bits 29..14 become the output
    localparam int depth_lsb = 14;

    // Stepper register plus clamp register
    localparam int pipe_latency = 2;

    // Sideband fields that ride along with the attributes
    typedef struct packed {
        logic                        last;
        logic [keep_width-1:0]       keep;
        logic [screen_pos_width-1:0] spx;
        logic [screen_pos_width-1:0] spy;
        logic [index_width-1:0]      index;
    } pixel_side_t;

endpackage

// File: hdl/value_delay.sv
// Fixed-length delay line
// Shifts a payload of any packed type through delay register stages

`timescale 1ns/100ps

module value_delay #(
    parameter type payload_t = logic,
    parameter int  delay     = 1
)
(
    input  logic     aclk,
    input  logic     arst_n,
    input  payload_t din,
    output payload_t dout
);

    payload_t stage [delay];

    always_ff @(posedge aclk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            for (int i = 0; i < delay; i++)
            begin
                stage[i] <= '0;
            end
        end
        else
        begin
            stage[0] <= din;
            for (int i = 1; i < delay; i++)
            begin
                stage[i] <= stage[i - 1];
            end
        end
    end

    assign dout = stage[delay - 1];

endmodule

// File: hdl/attr_stepper.sv
// Attribute stepper
// Five running accumulators (r, g, b, a, z) driven by the rasterizer step commands

`timescale 1ns/100ps

module attr_stepper (
    input  logic                                          aclk,
    input  logic                                          arst_n,
    input  logic                                          valid,
    input  logic        [attr_interp_pkg::cmd_width-1:0]    cmd,

    input  logic signed [attr_interp_pkg::attrib_width-1:0] color_r,   // S7.24
    input  logic signed [attr_interp_pkg::attrib_width-1:0] color_g,
    input  logic signed [attr_interp_pkg::attrib_width-1:0] color_b,
    input  logic signed [attr_interp_pkg::attrib_width-1:0] color_a,
    input  logic signed [attr_interp_pkg::attrib_width-1:0] color_r_inc_x,
    input  logic signed [attr_interp_pkg::attrib_width-1:0] color_g_inc_x,
    input  logic signed [attr_interp_pkg::attrib_width-1:0] color_b_inc_x,
    input  logic signed [attr_interp_pkg::attrib_width-1:0] color_a_inc_x,
    input  logic signed [attr_interp_pkg::attrib_width-1:0] color_r_inc_y,
    input  logic signed [attr_interp_pkg::attrib_width-1:0] color_g_inc_y,
    input  logic signed [attr_interp_pkg::attrib_width-1:0] color_b_inc_y,
    input  logic signed [attr_interp_pkg::attrib_width-1:0] color_a_inc_y,
    input  logic signed [attr_interp_pkg::attrib_width-1:0] depth_z,   // S1.30
    input  logic signed [attr_interp_pkg::attrib_width-1:0] depth_z_inc_x,
    input  logic signed [attr_interp_pkg::attrib_width-1:0] depth_z_inc_y,

    output logic signed [attr_interp_pkg::attrib_width-1:0] acc_r,
    output logic signed [attr_interp_pkg::attrib_width-1:0] acc_g,
    output logic signed [attr_interp_pkg::attrib_width-1:0] acc_b,
    output logic signed [attr_interp_pkg::attrib_width-1:0] acc_a,
    output logic signed [attr_interp_pkg::attrib_width-1:0] acc_z
);

    // Next value of one accumulator for a given command
    function automatic logic signed [attr_interp_pkg::attrib_width-1:0] next_acc(
        input logic signed [attr_interp_pkg::attrib_width-1:0] acc,
        input logic signed [attr_interp_pkg::attrib_width-1:0] start,
        input logic signed [attr_interp_pkg::attrib_width-1:0] inc_x,
        input logic signed [attr_interp_pkg::attrib_width-1:0] inc_y,
        input logic        [attr_interp_pkg::cmd_width-1:0]    step_cmd
    );
        case (step_cmd)
            attr_interp_pkg::cmd_init:  next_acc = start;
            attr_interp_pkg::cmd_x_inc: next_acc = acc + inc_x;
            attr_interp_pkg::cmd_x_dec: next_acc = acc - inc_x;
            attr_interp_pkg::cmd_y_inc: next_acc = acc + inc_y;
            default:                    next_acc = acc;
        endcase
    endfunction

    always_ff @(posedge aclk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            acc_r <= '0;
            acc_g <= '0;
            acc_b <= '0;
            acc_a <= '0;
            acc_z <= '0;
        end
        else if (valid)    // Non-pixel beats step too
        begin
            acc_r <= next_acc(acc_r, color_r, color_r_inc_x, color_r_inc_y, cmd);
            acc_g <= next_acc(acc_g, color_g, color_g_inc_x, color_g_inc_y, cmd);
            acc_b <= next_acc(acc_b, color_b, color_b_inc_x, color_b_inc_y, cmd);
            acc_a <= next_acc(acc_a, color_a, color_a_inc_x, color_a_inc_y, cmd);
            acc_z <= next_acc(acc_z, depth_z, depth_z_inc_x, depth_z_inc_y, cmd);
        end
    end

endmodule

// File: hdl/attr_clamp.sv
// Attribute clamp
// Registered truncation and saturation of the colour and depth accumulators

`timescale 1ns/100ps

module attr_clamp (
    input  logic                                      aclk,
    input  logic                                      arst_n,
    input  logic [attr_interp_pkg::attrib_width-1:0]  acc_r,
    input  logic [attr_interp_pkg::attrib_width-1:0]  acc_g,
    input  logic [attr_interp_pkg::attrib_width-1:0]  acc_b,
    input  logic [attr_interp_pkg::attrib_width-1:0]  acc_a,
    input  logic [attr_interp_pkg::attrib_width-1:0]  acc_z,
    output logic [attr_interp_pkg::color_width-1:0]   color_r,
    output logic [attr_interp_pkg::color_width-1:0]   color_g,
    output logic [attr_interp_pkg::color_width-1:0]   color_b,
    output logic [attr_interp_pkg::color_width-1:0]   color_a,
    output logic [attr_interp_pkg::depth_width-1:0]   depth_z
);

    localparam int fx_width = attr_interp_pkg::color_msb - attr_interp_pkg::color_lsb + 1;

    // S7.8 slice to U0.8, negative to 0 and 1.0 or more to full scale
    function automatic logic [attr_interp_pkg::color_width-1:0] sat_color(
        input logic [attr_interp_pkg::attrib_width-1:0] acc
    );
        logic [fx_width-1:0] fx;
        fx = acc[attr_interp_pkg::color_msb : attr_interp_pkg::color_lsb];
        if (fx[fx_width-1])
            sat_color = '0;
        else if (|fx[fx_width-2 : attr_interp_pkg::color_width])
            sat_color = '1;
        else
            sat_color = fx[attr_interp_pkg::color_width-1:0];
    endfunction

    // S1.30 to U0.16
    function automatic logic [attr_interp_pkg::depth_width-1:0] sat_depth(
        input logic [attr_interp_pkg::attrib_width-1:0] acc
    );
        if (acc[attr_interp_pkg::attrib_width-1])
            sat_depth = '0;
        else if (acc[attr_interp_pkg::attrib_width-2])
            sat_depth = '1;
        else
            sat_depth = acc[attr_interp_pkg::depth_lsb +: attr_interp_pkg::depth_width];
    endfunction

    always_ff @(posedge aclk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            color_r <= '0;
            color_g <= '0;
            color_b <= '0;
            color_a <= '0;
            depth_z <= '0;
        end
        else
        begin
            color_r <= sat_color(acc_r);
            color_g <= sat_color(acc_g);
            color_b <= sat_color(acc_b);
            color_a <= sat_color(acc_a);
            depth_z <= sat_depth(acc_z);
        end
    end

endmodule

// File: hdl/attr_interp_top.sv
// Pixel attribute interpolator
// Steps colour and depth per rasterizer beat, emits clamped attributes per pixel

`timescale 1ns/100ps

module attr_interp_top (
    input  logic                                            aclk,
    input  logic                                            arst_n,

    // Rasterizer stream
    input  logic                                            s_valid,
    input  logic                                            s_last,
    input  logic        [attr_interp_pkg::keep_width-1:0]       s_keep,
    input  logic        [attr_interp_pkg::screen_pos_width-1:0] s_spx,
    input  logic        [attr_interp_pkg::screen_pos_width-1:0] s_spy,
    input  logic        [attr_interp_pkg::index_width-1:0]      s_index,
    input  logic                                            s_pixel,
    input  logic        [attr_interp_pkg::cmd_width-1:0]        s_cmd,

    // Triangle attributes, stable while stepping
    input  logic signed [attr_interp_pkg::attrib_width-1:0] color_r,
    input  logic signed [attr_interp_pkg::attrib_width-1:0] color_g,
    input  logic signed [attr_interp_pkg::attrib_width-1:0] color_b,
    input  logic signed [attr_interp_pkg::attrib_width-1:0] color_a,
    input  logic signed [attr_interp_pkg::attrib_width-1:0] color_r_inc_x,
    input  logic signed [attr_interp_pkg::attrib_width-1:0] color_g_inc_x,
    input  logic signed [attr_interp_pkg::attrib_width-1:0] color_b_inc_x,
    input  logic signed [attr_interp_pkg::attrib_width-1:0] color_a_inc_x,
    input  logic signed [attr_interp_pkg::attrib_width-1:0] color_r_inc_y,
    input  logic signed [attr_interp_pkg::attrib_width-1:0] color_g_inc_y,
    input  logic signed [attr_interp_pkg::attrib_width-1:0] color_b_inc_y,
    input  logic signed [attr_interp_pkg::attrib_width-1:0] color_a_inc_y,
    input  logic signed [attr_interp_pkg::attrib_width-1:0] depth_z,
    input  logic signed [attr_interp_pkg::attrib_width-1:0] depth_z_inc_x,
    input  logic signed [attr_interp_pkg::attrib_width-1:0] depth_z_inc_y,

    // Interpolated pixel stream
    output logic                                            m_valid,
    output logic                                            m_last,
    output logic        [attr_interp_pkg::keep_width-1:0]       m_keep,
    output logic        [attr_interp_pkg::screen_pos_width-1:0] m_spx,
    output logic        [attr_interp_pkg::screen_pos_width-1:0] m_spy,
    output logic        [attr_interp_pkg::index_width-1:0]      m_index,
    output logic        [attr_interp_pkg::color_width-1:0]      m_color_r,
    output logic        [attr_interp_pkg::color_width-1:0]      m_color_g,
    output logic        [attr_interp_pkg::color_width-1:0]      m_color_b,
    output logic        [attr_interp_pkg::color_width-1:0]      m_color_a,
    output logic        [attr_interp_pkg::depth_width-1:0]      m_depth_z
);

    logic signed [attr_interp_pkg::attrib_width-1:0] acc_r;
    logic signed [attr_interp_pkg::attrib_width-1:0] acc_g;
    logic signed [attr_interp_pkg::attrib_width-1:0] acc_b;
    logic signed [attr_interp_pkg::attrib_width-1:0] acc_a;
    logic signed [attr_interp_pkg::attrib_width-1:0] acc_z;
    attr_interp_pkg::pixel_side_t                    side_in;
    attr_interp_pkg::pixel_side_t                    side_out;
    logic                                            pix_valid;

    ////////////////////////////////////////
    // Attribute path
    ////////////////////////////////////////
    attr_stepper u_stepper (
        .aclk          (aclk),
        .arst_n        (arst_n),
        .valid         (s_valid),
        .cmd           (s_cmd),
        .color_r       (color_r),
        .color_g       (color_g),
        .color_b       (color_b),
        .color_a       (color_a),
        .color_r_inc_x (color_r_inc_x),
        .color_g_inc_x (color_g_inc_x),
        .color_b_inc_x (color_b_inc_x),
        .color_a_inc_x (color_a_inc_x),
        .color_r_inc_y (color_r_inc_y),
        .color_g_inc_y (color_g_inc_y),
        .color_b_inc_y (color_b_inc_y),
        .color_a_inc_y (color_a_inc_y),
        .depth_z       (depth_z),
        .depth_z_inc_x (depth_z_inc_x),
        .depth_z_inc_y (depth_z_inc_y),
        .acc_r         (acc_r),
        .acc_g         (acc_g),
        .acc_b         (acc_b),
        .acc_a         (acc_a),
        .acc_z         (acc_z)
    );

    attr_clamp u_clamp (
        .aclk    (aclk),
        .arst_n  (arst_n),
        .acc_r   (acc_r),
        .acc_g   (acc_g),
        .acc_b   (acc_b),
        .acc_a   (acc_a),
        .acc_z   (acc_z),
        .color_r (m_color_r),
        .color_g (m_color_g),
        .color_b (m_color_b),
        .color_a (m_color_a),
        .depth_z (m_depth_z)
    );

    ////////////////////////////////////////
    // Sideband path, matched to the attribute latency
    ////////////////////////////////////////
    assign side_in.last  = s_last;
    assign side_in.keep  = s_keep;
    assign side_in.spx   = s_spx;
    assign side_in.spy   = s_spy;
    assign side_in.index = s_index;
    assign pix_valid     = s_valid & s_pixel;   // Only pixels leave the block

    value_delay #(
        .payload_t (attr_interp_pkg::pixel_side_t),
        .delay     (attr_interp_pkg::pipe_latency)
    ) u_side_delay (
        .aclk   (aclk),
        .arst_n (arst_n),
        .din    (side_in),
        .dout   (side_out)
    );

    value_delay #(
        .payload_t (logic),
        .delay     (attr_interp_pkg::pipe_latency)
    ) u_valid_delay (
        .aclk   (aclk),
        .arst_n (arst_n),
        .din    (pix_valid),
        .dout   (m_valid)
    );

    assign m_last  = side_out.last;
    assign m_keep  = side_out.keep;
    assign m_spx   = side_out.spx;
    assign m_spy   = side_out.spy;
    assign m_index = side_out.index;

endmodule

// File: sim/attr_interp_sva.sv
// Attribute interpolator assertions
// Output valid timing against the input stream, reset state, known attributes

`timescale 1ns/100ps

module attr_interp_sva (
    input logic        aclk,
    input logic        arst_n,
    input logic        s_valid,
    input logic        s_pixel,
    input logic        m_valid,
    input logic [7:0]  m_color_r,
    input logic [7:0]  m_color_g,
    input logic [7:0]  m_color_b,
    input logic [7:0]  m_color_a,
    input logic [15:0] m_depth_z
);

    a_reset_quiet: assert property (@(posedge aclk) !arst_n |-> !m_valid)
        else $error("m_valid high during reset");

    a_valid_delay: assert property (@(posedge aclk) disable iff (!arst_n)
        m_valid == $past(s_valid & s_pixel, attr_interp_pkg::pipe_latency))
        else $error("m_valid does not follow pixel beats");

    // No X on attributes of a live pixel
    a_known: assert property (@(posedge aclk) disable iff (!arst_n)
        m_valid |-> !$isunknown({m_color_r, m_color_g, m_color_b, m_color_a, m_depth_z}))
        else $error("unknown bits on output attributes");

endmodule

bind attr_interp_top attr_interp_sva u_sva (.*);

// File: sim/attr_interp_tb.sv
// Attribute interpolator testbench
// Steps random triangles through the DUT and checks every pixel against a model

`timescale 1ns/100ps

module attr_interp_tb;

    typedef struct {
        logic                                            last;
        logic [attr_interp_pkg::keep_width-1:0]          keep;
        logic [attr_interp_pkg::screen_pos_width-1:0]    spx;
        logic [attr_interp_pkg::screen_pos_width-1:0]    spy;
        logic [attr_interp_pkg::index_width-1:0]         index;
        logic [attr_interp_pkg::color_width-1:0]         col [4];
        logic [attr_interp_pkg::depth_width-1:0]         z;
        int                                              due;
    } pixel_exp_t;

    localparam int total_beats = 46;    // Beats sent by the six tests
    localparam int num_tests   = 6;
    localparam int cycle_limit = total_beats + num_tests * (attr_interp_pkg::pipe_latency + 20);

    logic        aclk = 1'b0;
    logic        arst_n;
    logic        s_valid, s_last, s_pixel;
    logic [0:0]  s_keep;
    logic [10:0] s_spx, s_spy;
    logic [31:0] s_index;
    logic [1:0]  s_cmd;
    logic signed [31:0] start [5];      // r, g, b, a, z
    logic signed [31:0] inc_x [5];
    logic signed [31:0] inc_y [5];
    logic signed [31:0] model_acc [5];
    logic        m_valid, m_last;
    logic [0:0]  m_keep;
    logic [10:0] m_spx, m_spy;
    logic [31:0] m_index;
    logic [7:0]  m_color_r, m_color_g, m_color_b, m_color_a;
    logic [15:0] m_depth_z;

    pixel_exp_t  exp_q [$];
    int          seed = 36;
    int          cycles = 0;
    int          errors = 0;
    int          errors_at_start;
    int          tests_failed = 0;

    always #50 aclk = ~aclk;

    always @(posedge aclk)
        cycles <= cycles + 1;

    attr_interp_top dut (
        .aclk (aclk), .arst_n (arst_n),
        .s_valid (s_valid), .s_last (s_last), .s_keep (s_keep), .s_spx (s_spx),
        .s_spy (s_spy), .s_index (s_index), .s_pixel (s_pixel), .s_cmd (s_cmd),
        .color_r (start[0]), .color_g (start[1]), .color_b (start[2]), .color_a (start[3]),
        .color_r_inc_x (inc_x[0]), .color_g_inc_x (inc_x[1]),
        .color_b_inc_x (inc_x[2]), .color_a_inc_x (inc_x[3]),
        .color_r_inc_y (inc_y[0]), .color_g_inc_y (inc_y[1]),
        .color_b_inc_y (inc_y[2]), .color_a_inc_y (inc_y[3]),
        .depth_z (start[4]), .depth_z_inc_x (inc_x[4]), .depth_z_inc_y (inc_y[4]),
        .m_valid (m_valid), .m_last (m_last), .m_keep (m_keep), .m_spx (m_spx),
        .m_spy (m_spy), .m_index (m_index), .m_color_r (m_color_r),
        .m_color_g (m_color_g), .m_color_b (m_color_b), .m_color_a (m_color_a),
        .m_depth_z (m_depth_z)
    );

    ////////////////////////////////////////
    // Reference model
    ////////////////////////////////////////
    function automatic logic signed [31:0] step_ref(input logic signed [31:0] acc,
        input logic signed [31:0] st, input logic signed [31:0] ix,
        input logic signed [31:0] iy, input logic [1:0] cmd);
        if (cmd == 2'd0)
            return st;
        else if (cmd == 2'd1)
            return acc + ix;
        else if (cmd == 2'd2)
            return acc - ix;
        return acc + iy;
    endfunction

    function automatic logic [7:0] color_ref(input logic signed [31:0] acc);
        if (acc < 0)
            return 8'd0;
        else if (acc >= 32'sh0100_0000)    // 1.0 in S7.24
            return 8'hff;
        return acc[23:16];
    endfunction

    function automatic logic [15:0] depth_ref(input logic [31:0] acc);
        if (acc[31])
            return 16'h0000;
        else if (acc[30])
            return 16'hffff;
        return acc[29:14];
    endfunction

    task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp)
        begin
            errors++;
            $display("FAIL %s: got %h, expected %h", name, got, exp);
        end
    endtask

    ////////////////////////////////////////
    // Stimulus
    ////////////////////////////////////////
    task automatic set_attrs(input logic signed [31:0] st [5]);
        @(posedge aclk);
        s_valid <= 1'b0;
        for (int i = 0; i < 5; i++)
        begin
            start[i] <= st[i];
            inc_x[i] <= $random(seed) >>> 12;   // Small signed steps
            inc_y[i] <= $random(seed) >>> 12;
        end
    endtask

    task automatic send_beat(input logic [1:0] cmd, input logic pixel);
        pixel_exp_t e;
        e.last  = $random(seed);
        e.keep  = $random(seed);
        e.spx   = $random(seed);
        e.spy   = $random(seed);
        e.index = $random(seed);
        @(posedge aclk);
        s_valid <= 1'b1;
        s_cmd   <= cmd;
        s_pixel <= pixel;
        s_last  <= e.last;
        s_keep  <= e.keep;
        s_spx   <= e.spx;
        s_spy   <= e.spy;
        s_index <= e.index;
        for (int i = 0; i < 5; i++)
            model_acc[i] = step_ref(model_acc[i], start[i], inc_x[i], inc_y[i], cmd);
        if (pixel)
        begin
            for (int i = 0; i < 4; i++)
                e.col[i] = color_ref(model_acc[i]);
            e.z   = depth_ref(model_acc[4]);
            e.due = cycles + 1 + attr_interp_pkg::pipe_latency;
            exp_q.push_back(e);
        end
    endtask

    task automatic end_test(input string name);
        @(posedge aclk);
        s_valid <= 1'b0;
        while (exp_q.size() > 0)
            @(posedge aclk);
        @(posedge aclk);    // Room for a stray extra output
        if (errors == errors_at_start)
            $display("Test %s: passed", name);
        else
        begin
            tests_failed++;
            $display("Test %s: failed with %0d errors", name, errors - errors_at_start);
        end
        errors_at_start = errors;
    endtask

    function automatic logic signed [31:0] rand_color();
        return $random(seed) & 32'h00ff_ffff;   // 0.0 up to just under 1.0
    endfunction

    ////////////////////////////////////////
    // Comparison at the falling edge
    ////////////////////////////////////////
    always @(negedge aclk)
    begin
        pixel_exp_t e;
        if (arst_n && m_valid)
        begin
            if (exp_q.size() == 0)
            begin
                errors++;
                $display("Output pixel at cycle %0d was not expected", cycles);
            end
            else
            begin
                e = exp_q.pop_front();
                if (e.due != cycles)
                begin
                    errors++;
                    $display("Pixel came at cycle %0d instead of cycle %0d", cycles, e.due);
                end
                check("m_color_r", m_color_r, e.col[0]);
                check("m_color_g", m_color_g, e.col[1]);
                check("m_color_b", m_color_b, e.col[2]);
                check("m_color_a", m_color_a, e.col[3]);
                check("m_depth_z", m_depth_z, e.z);
                check("m_last", m_last, e.last);
                check("m_keep", m_keep, e.keep);
                check("m_spx", m_spx, e.spx);
                check("m_spy", m_spy, e.spy);
                check("m_index", m_index, e.index);
            end
        end
        if (exp_q.size() > 0 && exp_q[0].due < cycles)
        begin
            errors++;
            $display("Expected pixel due at cycle %0d never came out", exp_q[0].due);
            void'(exp_q.pop_front());
        end
    end

    always @(posedge aclk)
    begin
        if (cycles >= cycle_limit)
        begin
            $display("Run stopped by timeout after %0d cycles", cycles);
            $display("Finished with errors");
            $finish;
        end
    end

    initial
    begin
        logic signed [31:0] st [5];
        arst_n  = 1'b0;
        s_valid = 1'b0;
        s_last  = 1'b0;
        s_keep  = '0;
        s_spx   = '0;
        s_spy   = '0;
        s_index = '0;
        s_pixel = 1'b0;
        s_cmd   = '0;
        for (int i = 0; i < 5; i++)
        begin
            start[i]     = '0;
            inc_x[i]     = '0;
            inc_y[i]     = '0;
            model_acc[i] = '0;
        end
        errors_at_start = 0;
        repeat (3) @(posedge aclk);
        arst_n <= 1'b1;

        st = '{32'h0012_3456, 32'h0080_0000, 32'h00ff_ffff, 32'h0000_0000, 32'h2345_6789};
        set_attrs(st);
        send_beat(attr_interp_pkg::cmd_init, 1'b1);
        end_test("init");

        st = '{rand_color(), rand_color(), rand_color(), rand_color(), 32'h2000_0000};
        set_attrs(st);
        send_beat(attr_interp_pkg::cmd_init, 1'b1);
        repeat (8) send_beat(attr_interp_pkg::cmd_x_inc, 1'b1);
        repeat (8) send_beat(attr_interp_pkg::cmd_x_dec, 1'b1);   // Back to the start
        end_test("x_steps");

        st = '{rand_color(), rand_color(), rand_color(), rand_color(), 32'h1800_0000};
        set_attrs(st);
        send_beat(attr_interp_pkg::cmd_init, 1'b1);
        repeat (4) send_beat(attr_interp_pkg::cmd_x_inc, 1'b1);
        send_beat(attr_interp_pkg::cmd_y_inc, 1'b1);
        repeat (4) send_beat(attr_interp_pkg::cmd_x_dec, 1'b1);
        end_test("y_step");

        st = '{32'hff00_0000, 32'h0100_0000, 32'h7fff_ffff, 32'h0080_0000, 32'h8000_0000};
        set_attrs(st);
        send_beat(attr_interp_pkg::cmd_init, 1'b1);
        st = '{32'h00ff_ffff, 32'hffff_ffff, 32'h0000_0000, 32'h0200_0000, 32'h4000_0000};
        set_attrs(st);
        send_beat(attr_interp_pkg::cmd_init, 1'b1);
        end_test("saturation");

        st = '{rand_color(), rand_color(), rand_color(), rand_color(), 32'h1000_0000};
        set_attrs(st);
        send_beat(attr_interp_pkg::cmd_init, 1'b1);
        repeat (3) send_beat(attr_interp_pkg::cmd_x_inc, 1'b0);
        send_beat(attr_interp_pkg::cmd_x_inc, 1'b1);
        end_test("non_pixel");

        st = '{rand_color(), rand_color(), rand_color(), rand_color(), 32'h0c00_0000};
        set_attrs(st);
        send_beat(attr_interp_pkg::cmd_init, 1'b1);
        repeat (10) send_beat(attr_interp_pkg::cmd_x_inc, 1'b1);
        end_test("sideband");

        $display("Tests run %0d, failed %0d, errors %0d", num_tests, tests_failed, errors);
        if (errors == 0)
            $display("Finished with no errors");
        else
            $display("Finished with errors");
        $finish;
    end

endmodule

// File: attr_interp_top.f
hdl/attr_interp_pkg.sv
hdl/value_delay.sv
hdl/attr_stepper.sv
hdl/attr_clamp.sv
hdl/attr_interp_top.sv
sim/attr_interp_sva.sv
sim/attr_interp_tb.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the attribute interpolator testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
    -f attr_interp_top.f --top-module attr_interp_tb -o attr_interp_sim \
    > build.log 2>&1 || { cat build.log; exit 1; }

./obj_dir/attr_interp_sim > sim.log 2>&1 ; cat sim.log

! grep -q "Finished with errors" sim.log && grep -q "Finished with no errors" sim.log \
    && exit 0 || exit 1
